/* dla_cases.txt */
# Columns: test name, 16-bit walker seed in hex
# The second case runs over the frame left by the first
first_grow   1D2C
regrow_full  BEEF
zero_seed    0000
all_ones     FFFF

/* dla_sram.f */
dla_pkg.sv
vga_sync.sv
sram_controller.sv
frame_buffer_arbiter.sv
dla_walker.sv
dla_frame_buffer_sram.sv
sram_model.sv
tb_dla_frame_buffer_sram.sv

/* tb_dla_frame_buffer_sram.sv */
// ------------------------------
// Testbench for the DLA frame buffer
// Case replay, frame, sticking, scan-out and sync checks
// ------------------------------
`timescale 1ns/1ps

module tb_dla_frame_buffer_sram;
   import dla_pkg::*;

   localparam int HSIZE        = 16;
   localparam int VSIZE        = 12;
   localparam int N_PARTICLES  = 20;
   localparam int NPIX         = HSIZE * VSIZE;
   localparam int CENTRE       = (VSIZE / 2) * HSIZE + HSIZE / 2;
   localparam int H_TOTAL      = HSIZE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL      = VSIZE + V_FRONT + V_SYNC + V_BACK;
   localparam int HS_START     = HSIZE + H_FRONT;
   localparam int VS_START     = VSIZE + V_FRONT;
   localparam int LINE_CYCLES  = H_TOTAL * PIXEL_DIV;
   localparam int FRAME_CYCLES = LINE_CYCLES * V_TOTAL;
   localparam int SLOT_WAIT    = (HSIZE + 1) * PIXEL_DIV;   // Longest wait for a free slot
   localparam int CLEAR_CYCLES = NPIX * SLOT_WAIT;
   localparam int WALK_CYCLES  = 16000;                     // One particle's walk
   localparam int CASE_CYCLES  = CLEAR_CYCLES + N_PARTICLES * WALK_CYCLES
                                 + 2 * FRAME_CYCLES + 64;

   logic        sys_clk;
   logic        sys_rst;
   logic        start_req;
   logic [15:0] start_seed;
   logic        start_ack;
   logic        done;
   vga_out_t    vga;
   logic        sram_ce_n, sram_oe_n, sram_we_n;
   logic [1:0]  sram_be_n;
   pix_addr_t   sram_addr;
   wire [15:0]  sram_dq;

   logic [11:0] img [0:NPIX-1];   // Frame rebuilt from the write pins
   string       names[$];
   logic [15:0] seeds[$];
   string       cur_name;
   string       phase;
   string       line;
   string       rd_name;
   logic [15:0] rd_seed;
   int          fd;
   int          errors, test_errors, failed, tests;
   int          cycles, cycle_limit;

   dla_frame_buffer_sram #(.HSIZE(HSIZE), .VSIZE(VSIZE), .N_PARTICLES(N_PARTICLES)) DUT (
      .sys_clk, .sys_rst, .start_req, .start_seed, .start_ack, .done, .vga,
      .sram_ce_n, .sram_oe_n, .sram_we_n, .sram_be_n, .sram_addr, .sram_dq
   );

   sram_model u_sram (
      .ce_n(sram_ce_n), .oe_n(sram_oe_n), .we_n(sram_we_n),
      .be_n(sram_be_n), .addr(sram_addr), .dq(sram_dq)
   );

   initial begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
         errors++;
         test_errors++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR %s: %s", cur_name, msg);
      errors++;
      test_errors++;
   endtask

   // Any of the four wrapped neighbours already set
   function automatic logic touches(input int a);
      int x, y;
      x = a % HSIZE;
      y = a / HSIZE;
      return (img[y * HSIZE + (x + 1) % HSIZE] != 0)
          || (img[y * HSIZE + (x + HSIZE - 1) % HSIZE] != 0)
          || (img[((y + 1) % VSIZE) * HSIZE + x] != 0)
          || (img[((y + VSIZE - 1) % VSIZE) * HSIZE + x] != 0);
   endfunction

   // ------------------------------
   // Write monitor and watchdog
   // ------------------------------
   always @(negedge sys_clk) begin
      if (!sys_rst && !sram_ce_n && !sram_we_n) begin
         if (sram_addr >= NPIX) begin
            report_error("write outside the frame");
         end else begin
            check({cur_name, " write byte enables"}, 0, sram_be_n);
            if (sram_dq[11:0] == PARTICLE_COLOR) begin
               check({cur_name, " stick on empty pixel"}, 0, img[sram_addr]);
               check({cur_name, " stick next to cluster"}, 1, touches(sram_addr));
            end
            img[sram_addr] = sram_dq[11:0];
         end
      end
   end

   always @(posedge sys_clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles in %s while %s", cycles, cur_name, phase);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic check_frame(input string name);
      int   count;
      rgb_t c;
      count = 0;
      for (int i = 0; i < NPIX; i++) begin
         c = u_sram.shadow[i][11:0];
         if (c != 12'h000) begin
            count++;
            check({name, " pixel colour"}, (i == CENTRE) ? SEED_COLOR : PARTICLE_COLOR, c);
         end
      end
      check({name, " centre pixel"}, SEED_COLOR, u_sram.shadow[CENTRE][11:0]);
      check({name, " pixel count"}, N_PARTICLES + 1, count);
   endtask

   // One frame starting at a vsync fall
   // Cycle 0 lies in pixel (0, VS_START)
   task automatic check_scanout(input string name);
      int   c, p, x, y, last_hf, last_vf;
      logic hs_q, vs_q;
      rgb_t exp_c;
      phase = "waiting for vsync to fall";
      vs_q  = vga.vsync;
      @(negedge sys_clk);
      while (!(vs_q && !vga.vsync)) begin
         vs_q = vga.vsync;
         @(negedge sys_clk);
      end
      hs_q    = vga.hsync;
      vs_q    = vga.vsync;
      last_hf = -1;
      last_vf = 0;
      phase   = "checking one frame of scan-out";
      for (c = 1; c <= FRAME_CYCLES; c++) begin
         @(negedge sys_clk);
         p = c / PIXEL_DIV;
         x = p % H_TOTAL;
         y = (p / H_TOTAL + VS_START) % V_TOTAL;
         if ((c % PIXEL_DIV == PIXEL_DIV / 2) && (c < FRAME_CYCLES)) begin   // Mid pixel
            exp_c = (x < HSIZE && y < VSIZE) ? u_sram.shadow[y * HSIZE + x][11:0] : 12'h000;
            check({name, " scan-out colour"}, exp_c, {vga.r, vga.g, vga.b});
            check({name, " hsync level"}, !(x >= HS_START && x < HS_START + H_SYNC), vga.hsync);
            check({name, " vsync level"}, !(y >= VS_START && y < VS_START + V_SYNC), vga.vsync);
         end
         if (hs_q && !vga.hsync) begin
            if (last_hf >= 0) check({name, " line period"}, LINE_CYCLES, c - last_hf);
            last_hf = c;
         end
         if (!hs_q && vga.hsync && last_hf >= 0)
            check({name, " hsync width"}, H_SYNC * PIXEL_DIV, c - last_hf);
         if (vs_q && !vga.vsync)
            check({name, " frame period"}, FRAME_CYCLES, c - last_vf);
         if (!vs_q && vga.vsync)
            check({name, " vsync width"}, V_SYNC * LINE_CYCLES, c - last_vf);
         hs_q = vga.hsync;
         vs_q = vga.vsync;
      end
      if (vs_q) report_error("vsync did not fall again after one frame");
   endtask

   task automatic run_case(input string name, input logic [15:0] seed);
      int delay;
      cur_name    = name;
      test_errors = 0;
      delay       = $urandom % 21;
      phase       = "waiting before start";
      repeat (delay) @(negedge sys_clk);
      start_seed = seed;
      start_req  = 1'b1;
      phase      = "waiting for start_ack to rise";
      @(negedge sys_clk);
      while (!start_ack) @(negedge sys_clk);
      if (done) report_error("done still high after start_ack rose");
      repeat (2) begin
         @(negedge sys_clk);
         if (!start_ack) report_error("start_ack fell while start_req was still high");
      end
      start_req = 1'b0;
      phase     = "waiting for start_ack to fall";
      @(negedge sys_clk);
      while (start_ack) @(negedge sys_clk);
      if (done) report_error("done high at the start of the run");
      phase = "waiting for done";
      while (!done) @(negedge sys_clk);
      check_frame(name);
      check_scanout(name);
      tests++;
      if (test_errors == 0) begin
         $display("%s (seed %h): ok", name, seed);
      end else begin
         $display("%s (seed %h): %0d errors", name, seed, test_errors);
         failed++;
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      sys_rst     = 1'b1;
      start_req   = 1'b0;
      start_seed  = '0;
      errors      = 0;
      failed      = 0;
      tests       = 0;
      cycles      = 0;
      cur_name    = "reset";
      phase       = "reading cases";
      test_errors = 0;
      cycle_limit = 64;
      void'($urandom(36));
      for (int i = 0; i < NPIX; i++) img[i] = '0;

      fd = $fopen("dla_cases.txt", "r");
      if (fd == 0) begin
         report_error("cannot open dla_cases.txt");
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;   // Comment or blank
            if ($sscanf(line, "%s %h", rd_name, rd_seed) == 2) begin
               names.push_back(rd_name);
               seeds.push_back(rd_seed);
            end
         end
         $fclose(fd);
      end
      if (names.size() == 0) report_error("no test cases were read");
      cycle_limit = 64 + names.size() * CASE_CYCLES;

      phase = "in reset";
      repeat (3) @(posedge sys_clk);
      @(negedge sys_clk);
      sys_rst = 1'b0;
      @(negedge sys_clk);
      check("reset start_ack", 0, start_ack);
      check("reset done", 0, done);
      check("reset hsync", 1, vga.hsync);
      check("reset vsync", 1, vga.vsync);
      check("reset colour", 0, {vga.r, vga.g, vga.b});
      check("reset sram_ce_n", 1, sram_ce_n);
      check("reset sram_oe_n", 1, sram_oe_n);
      check("reset sram_we_n", 1, sram_we_n);
      tests++;
      if (test_errors == 0) begin
         $display("reset: ok");
      end else begin
         $display("reset: %0d errors", test_errors);
         failed++;
      end

      for (int i = 0; i < names.size(); i++) run_case(names[i], seeds[i]);

      $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* sram_model.sv */
// ------------------------------
// Behavioural asynchronous SRAM
// Keeps a shadow copy of the low words for inspection
// ------------------------------
`timescale 1ns/1ps

module sram_model #(
   parameter int SHADOW_WORDS = 4096
) (
   input  logic        ce_n,
   input  logic        oe_n,
   input  logic        we_n,
   input  logic [1:0]  be_n,
   input  logic [17:0] addr,
   inout  wire [15:0]  dq
);
   logic [15:0] mem [0:(1 << 18) - 1];
   logic [15:0] shadow [0:SHADOW_WORDS - 1];
   logic [15:0] word;

   assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;   // Read

   initial begin
      for (int i = 0; i < (1 << 18); i++) mem[i] = '0;
      for (int i = 0; i < SHADOW_WORDS; i++) shadow[i] = '0;
   end

   // Write taken at the end of the we_n pulse
   always @(posedge we_n) begin
      if (!ce_n) begin
         word = mem[addr];
         if (!be_n[0]) word[7:0] = dq[7:0];
         if (!be_n[1]) word[15:8] = dq[15:8];
         mem[addr] = word;
         if (addr < SHADOW_WORDS) shadow[addr] = word;
      end
   end

endmodule

/* dla_frame_buffer_sram.sv */
// ------------------------------
// DLA in an SRAM frame buffer
// Walker, arbiter, SRAM controller and VGA sync
// ------------------------------
`timescale 1ns/1ps

module dla_frame_buffer_sram #(
   parameter int HSIZE       = 16,
   parameter int VSIZE       = 12,
   parameter int N_PARTICLES = 20
) (
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               start_req,
   input  logic [15:0]        start_seed,
   output logic               start_ack,
   output logic               done,
   output dla_pkg::vga_out_t  vga,
   output logic               sram_ce_n,
   output logic               sram_oe_n,
   output logic               sram_we_n,
   output logic [1:0]         sram_be_n,
   output dla_pkg::pix_addr_t sram_addr,
   inout  wire [15:0]         sram_dq
);
   import dla_pkg::*;

   // ------------------------------
   // Interconnect
   // ------------------------------
   logic      src_req, src_ack;       // Walker to arbiter
   mem_req_t  src_cmd;
   pix_data_t src_rdata;
   logic      mem_req, mem_ack;       // Arbiter to controller
   mem_req_t  mem_cmd;
   pix_data_t mem_rdata;
   logic      pix_tick, pix_active, hsync, vsync;
   coord_t    pix_x, pix_y;
   rgb_t      colour;

   assign vga = '{r: colour[11:8], g: colour[7:4], b: colour[3:0],
                  hsync: hsync, vsync: vsync};

   dla_walker #(.HSIZE(HSIZE), .VSIZE(VSIZE), .N_PARTICLES(N_PARTICLES)) u_walker (
      .sys_clk, .sys_rst, .start_req, .start_seed, .src_ack, .src_rdata,
      .start_ack, .done, .src_req, .src_cmd
   );

   frame_buffer_arbiter #(.HSIZE(HSIZE)) u_arbiter (
      .sys_clk, .sys_rst, .pix_tick, .pix_x, .pix_y, .pix_active,
      .src_req, .src_cmd, .mem_ack, .mem_rdata,
      .src_ack, .src_rdata, .mem_req, .mem_cmd, .colour
   );

   sram_controller u_sram_ctrl (
      .sys_clk, .sys_rst, .mem_req, .mem_cmd, .mem_ack, .mem_rdata,
      .sram_ce_n, .sram_oe_n, .sram_we_n, .sram_be_n, .sram_addr, .sram_dq
   );

   vga_sync #(.HSIZE(HSIZE), .VSIZE(VSIZE)) u_vga_sync (
      .sys_clk, .sys_rst, .pix_tick, .pix_x, .pix_y, .pix_active, .hsync, .vsync
   );

endmodule

/* dla_walker.sv */
// ------------------------------
// DLA particle source
// Clears the frame, plants the seed, walks particles until they stick
// ------------------------------
`timescale 1ns/1ps

module dla_walker #(
   parameter int HSIZE       = 16,
   parameter int VSIZE       = 12,
   parameter int N_PARTICLES = 20
) (
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               start_req,
   input  logic [15:0]        start_seed,
   input  logic               src_ack,
   input  dla_pkg::pix_data_t src_rdata,
   output logic               start_ack,
   output logic               done,
   output logic               src_req,
   output dla_pkg::mem_req_t  src_cmd
);
   import dla_pkg::*;

   localparam int        CW        = $clog2(HSIZE > VSIZE ? HSIZE : VSIZE);
   localparam int        PW        = $clog2(N_PARTICLES + 1);
   localparam pix_addr_t LAST_ADDR = pix_addr_t'(HSIZE * VSIZE - 1);
   localparam pix_addr_t SEED_ADDR = pix_addr_t'((VSIZE / 2) * HSIZE + HSIZE / 2);

   typedef enum logic [3:0] {
      W_IDLE, W_ACK, W_CLEAR, W_SEED, W_SPAWN, W_CHECK, W_NBR, W_STICK, W_MOVE
   } walk_state_t;

   walk_state_t   state;
   logic [15:0]   lfsr;
   logic [PW-1:0] p_cnt;
   logic [1:0]    nbr_idx;
   logic [1:0]    dir;
   logic          hit;
   logic          port_free;
   logic          port_done;
   logic          rd_set;     // Returned pixel is occupied
   coord_t        px, py;     // Walker position
   coord_t        nx, ny;     // Neighbour in direction dir
   coord_t        cand;       // Spawn offset along a border
   pix_addr_t     clr_addr;

   function automatic mem_req_t cmd(logic we, pix_addr_t a, rgb_t c);
      return '{we: we, addr: a, wdata: {4'h0, c}};
   endfunction

   assign port_free = !src_req && !src_ack;
   assign port_done = src_req && src_ack;
   assign rd_set    = (src_rdata[11:0] != 12'h000);
   assign dir       = (state == W_MOVE) ? lfsr[1:0] : nbr_idx;
   assign cand      = coord_t'(lfsr[2 +: CW]);

   // Up, down, left, right with wrap at the frame edges
   always_comb begin
      nx = px;
      ny = py;
      case (dir)
         2'd0:    ny = (py == '0) ? coord_t'(VSIZE - 1) : py - 10'd1;
         2'd1:    ny = (py == coord_t'(VSIZE - 1)) ? '0 : py + 10'd1;
         2'd2:    nx = (px == '0) ? coord_t'(HSIZE - 1) : px - 10'd1;
         default: nx = (px == coord_t'(HSIZE - 1)) ? '0 : px + 10'd1;
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         state     <= W_IDLE;
         start_ack <= 1'b0;
         done      <= 1'b0;
         src_req   <= 1'b0;
         lfsr      <= LFSR_DEFAULT;
      end else begin
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         if (port_done)
            src_req <= 1'b0;

         case (state)
            W_IDLE: if (start_req) begin
               lfsr      <= (start_seed == 16'h0) ? LFSR_DEFAULT : start_seed;
               start_ack <= 1'b1;
               done      <= 1'b0;
               state     <= W_ACK;
            end
            W_ACK: if (!start_req) begin
               start_ack <= 1'b0;
               clr_addr  <= '0;
               state     <= W_CLEAR;
            end
            W_CLEAR: begin
               if (port_free) begin
                  src_req <= 1'b1;
                  src_cmd <= cmd(1'b1, clr_addr, '0);
               end
               if (port_done) begin
                  clr_addr <= clr_addr + 18'd1;
                  if (clr_addr == LAST_ADDR) state <= W_SEED;
               end
            end
            W_SEED: begin
               if (port_free) begin
                  src_req <= 1'b1;
                  src_cmd <= cmd(1'b1, SEED_ADDR, SEED_COLOR);
               end
               if (port_done) begin
                  p_cnt <= '0;
                  state <= W_SPAWN;
               end
            end
            W_SPAWN: if (cand < coord_t'(lfsr[1] ? VSIZE : HSIZE)) begin
               case (lfsr[1:0])   // Border side
                  2'd0: begin px <= cand; py <= '0; end
                  2'd1: begin px <= cand; py <= coord_t'(VSIZE - 1); end
                  2'd2: begin px <= '0; py <= cand; end
                  default: begin px <= coord_t'(HSIZE - 1); py <= cand; end
               endcase
               state <= W_CHECK;
            end
            W_CHECK: begin   // Spawn must land on an empty pixel
               if (port_free) begin
                  src_req <= 1'b1;
                  src_cmd <= cmd(1'b0, pix_addr(px, py, HSIZE), '0);
               end
               if (port_done) begin
                  nbr_idx <= 2'd0;
                  hit     <= 1'b0;
                  state   <= rd_set ? W_SPAWN : W_NBR;
               end
            end
            W_NBR: begin
               if (port_free) begin
                  src_req <= 1'b1;
                  src_cmd <= cmd(1'b0, pix_addr(nx, ny, HSIZE), '0);
               end
               if (port_done) begin
                  hit     <= hit || rd_set;
                  nbr_idx <= nbr_idx + 2'd1;
                  if (nbr_idx == 2'd3) state <= (hit || rd_set) ? W_STICK : W_MOVE;
               end
            end
            // Only moves with all four neighbours empty, so the new pixel is empty too
            W_MOVE: begin
               px      <= nx;
               py      <= ny;
               nbr_idx <= 2'd0;
               hit     <= 1'b0;
               state   <= W_NBR;
            end
            W_STICK: begin
               if (port_free) begin
                  src_req <= 1'b1;
                  src_cmd <= cmd(1'b1, pix_addr(px, py, HSIZE), PARTICLE_COLOR);
               end
               if (port_done) begin
                  p_cnt <= p_cnt + 1'b1;
                  if (p_cnt == PW'(N_PARTICLES - 1)) begin
                     done  <= 1'b1;
                     state <= W_IDLE;
                  end else begin
                     state <= W_SPAWN;
                  end
               end
            end
            default: state <= W_IDLE;
         endcase
      end
   end

endmodule

/* frame_buffer_arbiter.sv */
// ------------------------------
// Frame buffer arbiter
// VGA fetch owns the tick slot, particle source gets free slots
// ------------------------------
`timescale 1ns/1ps

module frame_buffer_arbiter #(
   parameter int HSIZE = 16
) (
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               pix_tick,
   input  dla_pkg::coord_t    pix_x,
   input  dla_pkg::coord_t    pix_y,
   input  logic               pix_active,
   input  logic               src_req,
   input  dla_pkg::mem_req_t  src_cmd,
   input  logic               mem_ack,
   input  dla_pkg::pix_data_t mem_rdata,
   output logic               src_ack,
   output dla_pkg::pix_data_t src_rdata,
   output logic               mem_req,
   output dla_pkg::mem_req_t  mem_cmd,
   output dla_pkg::rgb_t      colour
);
   import dla_pkg::*;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_VGA,
      ARB_SRC,
      ARB_REL    // Wait for mem_ack to drop
   } arb_state_t;

   arb_state_t state;
   pix_data_t  fetch_q;   // Word for the next displayed pixel
   pix_addr_t  next_addr;
   logic       vga_need;

   // Active pixels prefetch their successor. In vertical blanking the
   // last slot of the line brings in pixel (0, 0) for the next frame
   assign vga_need  = pix_active || (pix_x == coord_t'(HSIZE - 1));
   assign next_addr = pix_active ? pix_addr(pix_x, pix_y, HSIZE) + 18'd1 : '0;

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         state   <= ARB_IDLE;
         mem_req <= 1'b0;
         src_ack <= 1'b0;
         colour  <= '0;
      end else begin
         if (src_ack && !src_req)
            src_ack <= 1'b0;
         if (pix_tick)
            colour <= pix_active ? rgb_t'(fetch_q[11:0]) : '0;

         case (state)
            ARB_IDLE: if (pix_tick) begin
               if (vga_need) begin
                  mem_req <= 1'b1;
                  mem_cmd <= '{we: 1'b0, addr: next_addr, wdata: '0};
                  state   <= ARB_VGA;
               end else if (src_req && !src_ack) begin   // Free slot
                  mem_req <= 1'b1;
                  mem_cmd <= src_cmd;
                  state   <= ARB_SRC;
               end
            end
            ARB_VGA: if (mem_ack) begin
               fetch_q <= mem_rdata;
               mem_req <= 1'b0;
               state   <= ARB_REL;
            end
            ARB_SRC: if (mem_ack) begin
               src_rdata <= mem_rdata;
               src_ack   <= 1'b1;
               mem_req   <= 1'b0;
               state     <= ARB_REL;
            end
            ARB_REL: if (!mem_ack) state <= ARB_IDLE;
            default: state <= ARB_IDLE;
         endcase
      end
   end

endmodule

/* sram_controller.sv */
// ------------------------------
// Asynchronous SRAM controller
// One read or write per four-phase request
// ------------------------------
`timescale 1ns/1ps

module sram_controller (
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               mem_req,
   input  dla_pkg::mem_req_t  mem_cmd,
   output logic               mem_ack,
   output dla_pkg::pix_data_t mem_rdata,
   output logic               sram_ce_n,
   output logic               sram_oe_n,
   output logic               sram_we_n,
   output logic [1:0]         sram_be_n,
   output dla_pkg::pix_addr_t sram_addr,
   inout  wire [15:0]         sram_dq
);
   import dla_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_ADDR,     // Address and chip enable settle
      S_STROBE,   // we_n or oe_n low
      S_ACK       // Wait for req to drop
   } ctrl_state_t;

   ctrl_state_t state;
   logic        we_q;
   logic        dq_oe;
   pix_data_t   wdata_q;

   assign sram_be_n = 2'b00;   // Whole words only
   assign sram_dq   = dq_oe ? wdata_q : 'z;

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         state     <= S_IDLE;
         mem_ack   <= 1'b0;
         sram_ce_n <= 1'b1;
         sram_oe_n <= 1'b1;
         sram_we_n <= 1'b1;
         dq_oe     <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (mem_req) begin
               sram_addr <= mem_cmd.addr;
               wdata_q   <= mem_cmd.wdata;
               we_q      <= mem_cmd.we;
               dq_oe     <= mem_cmd.we;   // Data out ahead of the strobe
               sram_ce_n <= 1'b0;
               state     <= S_ADDR;
            end
            S_ADDR: begin
               sram_we_n <= !we_q;
               sram_oe_n <= we_q;
               state     <= S_STROBE;
            end
            S_STROBE: begin
               sram_we_n <= 1'b1;       // Write lands on this rising edge
               sram_oe_n <= 1'b1;
               mem_rdata <= sram_dq;
               mem_ack   <= 1'b1;
               state     <= S_ACK;
            end
            S_ACK: begin
               sram_ce_n <= 1'b1;       // Held past we_n for the write
               dq_oe     <= 1'b0;
               if (!mem_req) begin
                  mem_ack <= 1'b0;
                  state   <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

/* vga_sync.sv */
// ------------------------------
// VGA sync generator
// Pixel tick divider, scan counters and sync pulses
// ------------------------------
`timescale 1ns/1ps

module vga_sync #(
   parameter int HSIZE = 16,
   parameter int VSIZE = 12
) (
   input  logic            sys_clk,
   input  logic            sys_rst,
   output logic            pix_tick,
   output dla_pkg::coord_t pix_x,
   output dla_pkg::coord_t pix_y,
   output logic            pix_active,
   output logic            hsync,
   output logic            vsync
);
   import dla_pkg::*;

   localparam int H_TOTAL  = HSIZE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL  = VSIZE + V_FRONT + V_SYNC + V_BACK;
   localparam int HS_START = HSIZE + H_FRONT;
   localparam int VS_START = VSIZE + V_FRONT;

   logic [$clog2(PIXEL_DIV)-1:0] div_cnt;
   logic                         tick_now;
   coord_t                       h_next;
   coord_t                       v_next;

   assign tick_now = (div_cnt == PIXEL_DIV - 1);

   // Next scan position
   always_comb begin
      h_next = pix_x + 10'd1;
      v_next = pix_y;
      if (pix_x == coord_t'(H_TOTAL - 1)) begin
         h_next = '0;
         v_next = (pix_y == coord_t'(V_TOTAL - 1)) ? '0 : pix_y + 10'd1;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         div_cnt    <= '0;
         pix_tick   <= 1'b0;
         pix_x      <= coord_t'(H_TOTAL - 1);   // First tick lands on (0, 0)
         pix_y      <= coord_t'(V_TOTAL - 1);
         pix_active <= 1'b0;
         hsync      <= 1'b1;
         vsync      <= 1'b1;
      end else begin
         pix_tick <= tick_now;
         if (tick_now) begin
            div_cnt    <= '0;
            pix_x      <= h_next;
            pix_y      <= v_next;
            pix_active <= (h_next < HSIZE) && (v_next < VSIZE);
            hsync      <= !((h_next >= HS_START) && (h_next < HS_START + H_SYNC));
            vsync      <= !((v_next >= VS_START) && (v_next < VS_START + V_SYNC));
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

endmodule

/* dla_pkg.sv */
// ------------------------------
// DLA frame buffer shared types
// Memory command, VGA timing and fixed colours
// ------------------------------
package dla_pkg;

   typedef logic [17:0] pix_addr_t;   // y * HSIZE + x
   typedef logic [15:0] pix_data_t;   // Colour in bits 11:0
   typedef logic [11:0] rgb_t;        // 4:4:4 red, green, blue
   typedef logic [9:0]  coord_t;

   // Command held stable with every req
   typedef struct packed {
      logic      we;
      pix_addr_t addr;
      pix_data_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
      logic       hsync;   // Active low
      logic       vsync;   // Active low
   } vga_out_t;

   // ------------------------------
   // Timing, in pixels and lines
   // ------------------------------
   localparam int PIXEL_DIV = 8;   // sys_clk cycles per pixel
   localparam int H_FRONT   = 2;
   localparam int H_SYNC    = 3;
   localparam int H_BACK    = 2;
   localparam int V_FRONT   = 1;
   localparam int V_SYNC    = 2;
   localparam int V_BACK    = 1;

   localparam rgb_t        SEED_COLOR     = 12'hF00;
   localparam rgb_t        PARTICLE_COLOR = 12'h0FF;
   localparam logic [15:0] LFSR_DEFAULT   = 16'hACE1;   // Used for a zero seed

   // Linear word address of pixel (x, y)
   function automatic pix_addr_t pix_addr(coord_t x, coord_t y, int hsize);
      return pix_addr_t'(y) * pix_addr_t'(hsize) + pix_addr_t'(x);
   endfunction

endpackage
